// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := gpio_subsys_tb
FILELIST   := gpio_subsys.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== gpio_subsys.f ====
+incdir+hdl
hdl/gpio_pkg.sv
hdl/gpio_bus_slave.sv
hdl/gpio_bank.sv
hdl/gpio_irq_collect.sv
hdl/gpio_subsys.sv
tests/gpio_subsys_asserts.sv
tests/gpio_subsys_tb.sv

// ==== hdl/gpio_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_bank (
    input  logic                 clk,
    input  logic                 rst,
    // command bus
    input  gpio_pkg::bank_cmd_t  cmd,
    input  logic                 sel,   // this bank addressed
    output gpio_pkg::gpio_word_t rdata,
    // pins
    output gpio_pkg::gpio_word_t gpio_out,
    output gpio_pkg::gpio_word_t gpio_oe,
    input  gpio_pkg::gpio_word_t gpio_in,
    output logic                 irq
);

    import gpio_pkg::*;

    // writable registers
    gpio_word_t out_en;    // output enable
    gpio_word_t out_data;  // output data
    gpio_word_t in_en;     // input enable
    gpio_word_t irq_en;    // irq enable
    gpio_word_t irq_mode;  // 0 level, 1 edge
    gpio_word_t irq_pol;   // 1 high/rising

    // input side
    gpio_word_t sync_meta;  // first sync stage
    gpio_word_t sync_in;    // second sync stage, usable
    gpio_word_t in_dly;     // previous sync_in for edges
    gpio_word_t in_data;    // masked input

    // interrupt side
    gpio_word_t irq_act;    // pin at its active level
    gpio_word_t irq_edge;   // selected transition this cycle
    gpio_word_t irq_stky;   // sticky edge bits
    gpio_word_t irq_clr;    // write 1 to clear
    gpio_word_t irq_stat;   // status as read back
    logic       wr;         // write to this bank

    assign wr = cmd.wen & sel;

    //////////////////////////////
    // pins
    //////////////////////////////

    assign gpio_out = out_data;
    assign gpio_oe  = out_en;

    // fixed two stage synchronizer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_meta <= '0;
            sync_in   <= '0;
            in_dly    <= '0;
        end else begin
            sync_meta <= gpio_in;
            sync_in   <= sync_meta;
            in_dly    <= sync_in;  // edge reference
        end
    end

    assign in_data = sync_in & in_en;

    //////////////////////////////
    // interrupts
    //////////////////////////////

    assign irq_act  = ~(sync_in ^ irq_pol);      // high when pin matches polarity
    assign irq_edge = (sync_in ^ in_dly) & irq_act;  // changed into active level
    assign irq_clr  = (wr && cmd.reg_addr == REG_IRQ_STAT) ? cmd.wdata : '0;

    // sticky bits, a new edge wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_stky <= '0;
        end else begin
            irq_stky <= (irq_stky & ~irq_clr) | (irq_edge & irq_mode);
        end
    end

    // level bits straight from the pins, edge bits from the sticky reg
    assign irq_stat = irq_en & ((irq_act & ~irq_mode) | (irq_stky & irq_mode));
    assign irq      = |irq_stat;

    //////////////////////////////
    // register write
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en   <= '0;
            out_data <= '0;
            in_en    <= '0;
            irq_en   <= '0;
            irq_mode <= '0;
            irq_pol  <= '0;
        end else if (wr) begin
            case (cmd.reg_addr)
                REG_OUT_EN:   out_en   <= cmd.wdata;
                REG_OUT_DATA: out_data <= cmd.wdata;
                REG_IN_EN:    in_en    <= cmd.wdata;
                REG_IRQ_EN:   irq_en   <= cmd.wdata;
                REG_IRQ_MODE: irq_mode <= cmd.wdata;
                REG_IRQ_POL:  irq_pol  <= cmd.wdata;
                default: ;  // input data read only, status handled above
            endcase
        end
    end

    //////////////////////////////
    // register read
    //////////////////////////////

    always_comb begin
        rdata = '0;
        case (cmd.reg_addr)
            REG_OUT_EN:   rdata = out_en;
            REG_OUT_DATA: rdata = out_data;
            REG_IN_EN:    rdata = in_en;
            REG_IN_DATA:  rdata = in_data;
            REG_IRQ_EN:   rdata = irq_en;
            REG_IRQ_MODE: rdata = irq_mode;
            REG_IRQ_POL:  rdata = irq_pol;
            REG_IRQ_STAT: rdata = irq_stat;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/gpio_bus_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_bus_slave (
    input  logic                 clk,
    input  logic                 rst,
    // host side, four-phase
    input  logic                 req,
    input  gpio_pkg::bus_req_t   req_data,
    output logic                 ack,
    output gpio_pkg::gpio_word_t rdata,
    // bank side
    output gpio_pkg::bank_cmd_t  cmd,
    output gpio_pkg::bank_sel_t  sel,
    input  gpio_pkg::gpio_word_t bank_rdata
);

    import gpio_pkg::*;

    bus_state_t state;      // current state
    bus_state_t state_nxt;  // next state
    logic       access;     // single access cycle

    //////////////////////////////
    // handshake fsm
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_nxt = ACCESS;  // new request seen
                end
            end
            ACCESS: begin
                state_nxt = ACK;  // always exactly one cycle
            end
            ACK: begin
                // hold ack until host lets go of req
                if (!req) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign access = (state == ACCESS);
    assign ack    = (state == ACK);  // stays up under back-pressure

    //////////////////////////////
    // decode
    //////////////////////////////

    // strobes only live in ACCESS
    always_comb begin
        cmd.wen      = access & req_data.we;
        cmd.reg_addr = req_data.reg_addr;
        cmd.wdata    = req_data.wdata;
        sel          = access ? (bank_sel_t'(1) << req_data.bank) : '0;  // one-hot
    end

    // response register, loaded on the same edge as the write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (access) begin
            rdata <= bank_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpio_irq_collect.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gpio_macros.svh"

module gpio_irq_collect (
    // per bank returns
    input  gpio_pkg::gpio_word_t [`GPIO_BANKS-1:0] bank_rdata,
    input  gpio_pkg::bank_sel_t                    bank_irq,
    // one-hot select from the slave
    input  gpio_pkg::bank_sel_t                    sel,
    // merged results
    output gpio_pkg::gpio_word_t                   rdata,
    output logic                                   irq
);

    //////////////////////////////
    // read data mux
    //////////////////////////////

    // and-or mux, zero with no bank selected
    always_comb begin
        rdata = '0;
        for (int i = 0; i < `GPIO_BANKS; i++) begin
            rdata |= bank_rdata[i] & {`GPIO_WIDTH{sel[i]}};  // mask unselected banks
        end
    end

    //////////////////////////////
    // interrupt
    //////////////////////////////

    // any bank asking
    assign irq = |bank_irq;

endmodule

`default_nettype wire

// ==== hdl/gpio_macros.svh ====
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

//////////////////////////////
// subsystem sizes
//////////////////////////////

// bank count and index width go together
`define GPIO_BANKS  4  // number of banks
`define GPIO_BANK_W 2  // bank index bits

// pins per bank
`define GPIO_WIDTH  16

// host side
`define GPIO_DATA_W `GPIO_WIDTH  // bus data width, same as pins
`define GPIO_REG_W  3            // eight registers per bank

`endif

// ==== hdl/gpio_pkg.sv ====
`default_nettype none

`include "gpio_macros.svh"

package gpio_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    typedef logic [`GPIO_WIDTH-1:0]  gpio_word_t;  // pins or one register
    typedef logic [`GPIO_REG_W-1:0]  reg_addr_t;   // register inside a bank
    typedef logic [`GPIO_BANK_W-1:0] bank_idx_t;   // bank number
    typedef logic [`GPIO_BANKS-1:0]  bank_sel_t;   // one-hot bank select

    // register map
    localparam reg_addr_t REG_OUT_EN   = 3'd0;  // output enable
    localparam reg_addr_t REG_OUT_DATA = 3'd1;  // output data
    localparam reg_addr_t REG_IN_EN    = 3'd2;  // input enable
    localparam reg_addr_t REG_IN_DATA  = 3'd3;  // input data, read only
    localparam reg_addr_t REG_IRQ_EN   = 3'd4;  // irq enable
    localparam reg_addr_t REG_IRQ_MODE = 3'd5;  // 0 level, 1 edge
    localparam reg_addr_t REG_IRQ_POL  = 3'd6;  // 1 high/rising, 0 low/falling
    localparam reg_addr_t REG_IRQ_STAT = 3'd7;  // write 1 clears edge bits

    //////////////////////////////
    // bus and bank commands
    //////////////////////////////

    // host request, held stable while req is high
    typedef struct packed {
        logic       we;        // 1 write, 0 read
        bank_idx_t  bank;
        reg_addr_t  reg_addr;
        gpio_word_t wdata;
    } bus_req_t;

    // broadcast to every bank
    typedef struct packed {
        logic       wen;  // one cycle strobe
        reg_addr_t  reg_addr;
        gpio_word_t wdata;
    } bank_cmd_t;

    // bus slave fsm
    typedef enum logic [1:0] {IDLE, ACCESS, ACK} bus_state_t;

endpackage

`default_nettype wire

// ==== hdl/gpio_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gpio_macros.svh"

module gpio_subsys (
    input  logic                                   clk,
    input  logic                                   rst,
    // host port
    input  logic                                   req,
    input  gpio_pkg::bus_req_t                     req_data,
    output logic                                   ack,
    output gpio_pkg::gpio_word_t                   rdata,
    output logic                                   irq,
    // pins, one word per bank
    output gpio_pkg::gpio_word_t [`GPIO_BANKS-1:0] gpio_out,
    output gpio_pkg::gpio_word_t [`GPIO_BANKS-1:0] gpio_oe,
    input  gpio_pkg::gpio_word_t [`GPIO_BANKS-1:0] gpio_in
);

    import gpio_pkg::*;

    bank_cmd_t                     cmd;         // broadcast command
    bank_sel_t                     sel;         // one-hot bank strobe
    gpio_word_t [`GPIO_BANKS-1:0]  bank_rdata;  // per bank read data
    bank_sel_t                     bank_irq;    // per bank irq
    gpio_word_t                    sel_rdata;   // selected bank data

    //////////////////////////////
    // bus front end
    //////////////////////////////

    gpio_bus_slave u_slave (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .rdata      (rdata),
        .cmd        (cmd),
        .sel        (sel),
        .bank_rdata (sel_rdata)
    );

    //////////////////////////////
    // banks
    //////////////////////////////

    for (genvar b = 0; b < `GPIO_BANKS; b++) begin : gen_bank
        gpio_bank u_bank (
            .clk      (clk),
            .rst      (rst),
            .cmd      (cmd),
            .sel      (sel[b]),  // own strobe bit
            .rdata    (bank_rdata[b]),
            .gpio_out (gpio_out[b]),
            .gpio_oe  (gpio_oe[b]),
            .gpio_in  (gpio_in[b]),
            .irq      (bank_irq[b])
        );
    end

    // read mux and irq merge
    gpio_irq_collect u_collect (
        .bank_rdata (bank_rdata),
        .bank_irq   (bank_irq),
        .sel        (sel),
        .rdata      (sel_rdata),
        .irq        (irq)
    );

endmodule

`default_nettype wire

// ==== tests/gpio_subsys_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_subsys_asserts (
    input logic                clk,
    input logic                rst,
    input logic                req,
    input logic                ack,
    input gpio_pkg::bank_cmd_t cmd,
    input gpio_pkg::bank_sel_t sel
);

    //////////////////////////////
    // handshake
    //////////////////////////////

    // ack only answers a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("ack rose with req low");

    //////////////////////////////
    // strobes
    //////////////////////////////

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else $error("bank select not one-hot");  // at most one bank

    // write strobe never stretches
    wen_single: assert property (@(posedge clk) disable iff (rst) cmd.wen |=> !cmd.wen)
        else $error("write strobe longer than one cycle");

endmodule

// attach to every bus slave
bind gpio_bus_slave gpio_subsys_asserts u_asserts (
    .clk (clk),
    .rst (rst),
    .req (req),
    .ack (ack),
    .cmd (cmd),
    .sel (sel)
);

`default_nettype wire

// ==== tests/gpio_subsys_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gpio_macros.svh"

module gpio_subsys_tb;

    import gpio_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 2000;  // per test, generous
    localparam int TIMEOUT_NS  = NUM_TESTS * TEST_CYCLES * 10;

    logic                         clk;
    logic                         rst;
    logic                         req;
    bus_req_t                     req_data;
    logic                         ack;
    gpio_word_t                   rdata;
    logic                         irq;
    gpio_word_t [`GPIO_BANKS-1:0] gpio_out;
    gpio_word_t [`GPIO_BANKS-1:0] gpio_oe;
    gpio_word_t [`GPIO_BANKS-1:0] gpio_in;

    integer     seed = 36;
    gpio_word_t model [`GPIO_BANKS][8];  // expected register contents
    reg_addr_t  wr_regs [6] = '{REG_OUT_EN, REG_OUT_DATA, REG_IN_EN,
                                REG_IRQ_EN, REG_IRQ_MODE, REG_IRQ_POL};

    gpio_subsys uut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rdata    (rdata),
        .irq      (irq),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .gpio_in  (gpio_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // hung handshake or runaway test
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, a bus handshake or test never finished", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check(input string name, input gpio_word_t got, input gpio_word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic gpio_word_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[`GPIO_WIDTH-1:0];
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);  // sample mid-cycle
    endtask

    // full four-phase cycle, ack expected two edges after req is seen
    task automatic bus_access(input logic we, input bank_idx_t bank, input reg_addr_t addr,
                              input gpio_word_t wdata, output gpio_word_t data);
        int cycles;
        @(posedge clk);
        req               <= 1'b1;
        req_data.we       <= we;
        req_data.bank     <= bank;
        req_data.reg_addr <= addr;
        req_data.wdata    <= wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack);
        check("ack latency", gpio_word_t'(cycles), gpio_word_t'(3));
        data = rdata;  // held while ack is up
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack);  // wait for return to idle
    endtask

    task automatic bus_write(input bank_idx_t bank, input reg_addr_t addr, input gpio_word_t v);
        gpio_word_t unused;
        bus_access(1'b1, bank, addr, v, unused);
        // input data and status are not stored
        if (addr != REG_IN_DATA && addr != REG_IRQ_STAT) begin
            model[bank][addr] = v;
        end
    endtask

    task automatic bus_read(input bank_idx_t bank, input reg_addr_t addr, output gpio_word_t v);
        bus_access(1'b0, bank, addr, '0, v);
    endtask

    task automatic read_check(input bank_idx_t bank, input reg_addr_t addr, input gpio_word_t exp);
        gpio_word_t v;
        bus_read(bank, addr, v);
        check($sformatf("bank%0d reg%0d", bank, addr), v, exp);
    endtask

    // writable registers and pins against the model
    task automatic check_bank(input int b);
        for (int i = 0; i < 6; i++) begin
            read_check(bank_idx_t'(b), wr_regs[i], model[b][wr_regs[i]]);
        end
        check($sformatf("gpio_out[%0d]", b), gpio_out[b], model[b][REG_OUT_DATA]);
        check($sformatf("gpio_oe[%0d]", b), gpio_oe[b], model[b][REG_OUT_EN]);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset();
        check("ack", gpio_word_t'(ack), '0);
        check("irq", gpio_word_t'(irq), '0);
        for (int b = 0; b < `GPIO_BANKS; b++) begin
            check($sformatf("gpio_out[%0d]", b), gpio_out[b], '0);
            check($sformatf("gpio_oe[%0d]", b), gpio_oe[b], '0);
            for (int r = 0; r < 8; r++) begin
                read_check(bank_idx_t'(b), reg_addr_t'(r), '0);  // every register
            end
        end
    endtask

    task automatic test_write_readback();
        gpio_word_t v;
        for (int b = 0; b < `GPIO_BANKS; b++) begin
            for (int i = 0; i < 6; i++) begin
                v = rand_word();
                bus_write(bank_idx_t'(b), wr_regs[i], v);
                read_check(bank_idx_t'(b), wr_regs[i], v);
            end
            check($sformatf("gpio_out[%0d]", b), gpio_out[b], model[b][REG_OUT_DATA]);
            check($sformatf("gpio_oe[%0d]", b), gpio_oe[b], model[b][REG_OUT_EN]);
        end
    endtask

    task automatic test_isolation();
        for (int i = 0; i < 6; i++) begin
            bus_write(2'd2, wr_regs[i], rand_word());  // bank 2 only
        end
        for (int b = 0; b < `GPIO_BANKS; b++) begin
            check_bank(b);
        end
    endtask

    task automatic test_input_path();
        gpio_word_t en;
        gpio_word_t pins;
        for (int b = 0; b < `GPIO_BANKS; b++) begin
            en   = rand_word();
            pins = rand_word();
            bus_write(bank_idx_t'(b), REG_IN_EN, en);
            @(posedge clk);
            gpio_in[b] <= pins;
            idle_cycles(2);  // synchronizer depth
            read_check(bank_idx_t'(b), REG_IN_DATA, pins & en);
        end
    endtask

    task automatic test_level_irq();
        gpio_word_t pins;
        gpio_word_t pol;
        gpio_word_t en;
        gpio_word_t act;
        for (int b = 0; b < `GPIO_BANKS; b++) begin
            bus_write(bank_idx_t'(b), REG_IRQ_EN, '0);  // quiet all banks
        end
        check("irq all disabled", gpio_word_t'(irq), '0);
        pol = rand_word();
        en  = rand_word();
        bus_write(2'd1, REG_IRQ_MODE, '0);
        bus_write(2'd1, REG_IRQ_POL, pol);
        bus_write(2'd1, REG_IRQ_EN, en);
        repeat (3) begin
            pins = rand_word();
            @(posedge clk);
            gpio_in[1] <= pins;
            idle_cycles(3);
            act = (pins & pol) | (~pins & ~pol);  // high or low active per bit
            read_check(2'd1, REG_IRQ_STAT, en & act);
            check("irq level", gpio_word_t'(irq), gpio_word_t'(|(en & act)));
        end
        bus_write(2'd1, REG_IRQ_EN, '0);
        check("irq after disable", gpio_word_t'(irq), '0);
    endtask

    task automatic test_edge_irq();
        gpio_word_t r;
        gpio_word_t bit_k;
        r     = rand_word();
        bit_k = gpio_word_t'(1) << r[3:0];  // one random pin
        @(posedge clk);
        gpio_in[3] <= '0;
        idle_cycles(3);
        bus_write(2'd3, REG_IRQ_MODE, '1);
        bus_write(2'd3, REG_IRQ_POL, '1);
        bus_write(2'd3, REG_IRQ_STAT, '1);  // drop stale sticky bits
        bus_write(2'd3, REG_IRQ_EN, bit_k);
        check("irq before edge", gpio_word_t'(irq), '0);
        @(posedge clk);
        gpio_in[3] <= bit_k;  // rising edge
        idle_cycles(3);
        read_check(2'd3, REG_IRQ_STAT, bit_k);
        check("irq after rise", gpio_word_t'(irq), gpio_word_t'(1));
        @(posedge clk);
        gpio_in[3] <= '0;  // sticky through the fall
        idle_cycles(3);
        read_check(2'd3, REG_IRQ_STAT, bit_k);
        check("irq sticky", gpio_word_t'(irq), gpio_word_t'(1));
        bus_write(2'd3, REG_IRQ_STAT, bit_k);
        read_check(2'd3, REG_IRQ_STAT, '0);
        check("irq after clear", gpio_word_t'(irq), '0);
        // falling edge alone sets nothing
        @(posedge clk);
        gpio_in[3] <= bit_k;
        idle_cycles(3);
        bus_write(2'd3, REG_IRQ_STAT, bit_k);
        read_check(2'd3, REG_IRQ_STAT, '0);
        @(posedge clk);
        gpio_in[3] <= '0;
        idle_cycles(3);
        read_check(2'd3, REG_IRQ_STAT, '0);
        check("irq after fall", gpio_word_t'(irq), '0);
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial begin
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        gpio_in  = '0;
        for (int b = 0; b < `GPIO_BANKS; b++) begin
            for (int r = 0; r < 8; r++) begin
                model[b][r] = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset();
        test_write_readback();
        test_isolation();
        test_input_path();
        test_level_irq();
        test_edge_irq();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
